// File: include/lcd_macros.svh
// ############################
// Panel timing and geometry constants
// for the ST7789 SPI display path
// ############################

`ifndef LCD_MACROS_SVH
`define LCD_MACROS_SVH

// Core clock in MHz
`define LCD_CLK_MHZ 25

// Hardware reset hold in us, 250 cycles at 25 MHz
`define LCD_RESET_US 10

// Visible area in pixels
`define LCD_X_SIZE 240
`define LCD_Y_SIZE 240

`define LCD_INIT_SIZE 34   // Bytes actually held in the init table
`define LCD_SLOT_CYCLES 16 // Two clocks per SPI bit

`endif

// File: design/lcd_pixel_pkg.sv
// ############################
// Pixel and screen coordinate types
// ############################

`include "lcd_macros.svh"

package lcd_pixel_pkg;

  // RGB565, red [15:11], green [10:5], blue [4:0]
  typedef logic [15:0] pixel_t;

  // 8 bits each for a 240 x 240 screen
  typedef logic [$clog2(`LCD_X_SIZE)-1:0] coord_x_t;
  typedef logic [$clog2(`LCD_Y_SIZE)-1:0] coord_y_t;

endpackage

// File: design/lcd_link_pkg.sv
// ############################
// SPI link and init sequencer types
// ############################

`include "lcd_macros.svh"

package lcd_link_pkg;

  typedef logic [7:0] byte_t; // One SPI payload byte

  // Must reach one past the last table entry
  typedef logic [$clog2(`LCD_INIT_SIZE + 1)-1:0] init_addr_t;

  typedef enum logic [2:0] {
    st_reset_hold,
    st_cmd,
    st_count,
    st_arg,
    st_delay_code,
    st_delay,
    st_pixels
  } seq_state_t;

endpackage

// File: design/lcd_init_rom.sv
// ############################
// ST7789 bring-up table
// cmd, count, args, delay code
// ############################

module lcd_init_rom
  import lcd_link_pkg::*;
(
  input  init_addr_t rom_addr,
  output byte_t      rom_byte
);

  always_comb begin
    case (rom_addr)
      6'd0:  rom_byte = 8'h01; // SWRESET
      6'd1:  rom_byte = 8'h80; // Delay, no args
      6'd2:  rom_byte = 8'h03; // 8 us
      6'd3:  rom_byte = 8'h11; // SLPOUT
      6'd4:  rom_byte = 8'h80;
      6'd5:  rom_byte = 8'h03;
      6'd6:  rom_byte = 8'h3A; // COLMOD
      6'd7:  rom_byte = 8'h01;
      6'd8:  rom_byte = 8'h55; // 16 bit per pixel
      6'd9:  rom_byte = 8'h36; // MADCTL
      6'd10: rom_byte = 8'h01;
      6'd11: rom_byte = 8'h00; // Normal scan order
      6'd12: rom_byte = 8'h2A; // CASET
      6'd13: rom_byte = 8'h04;
      6'd14: rom_byte = 8'h00; // Column start 0
      6'd15: rom_byte = 8'h00;
      6'd16: rom_byte = 8'h00; // Column end 239
      6'd17: rom_byte = 8'hEF;
      6'd18: rom_byte = 8'h2B; // RASET
      6'd19: rom_byte = 8'h04;
      6'd20: rom_byte = 8'h00; // Row start 0
      6'd21: rom_byte = 8'h00;
      6'd22: rom_byte = 8'h00; // Row end 239
      6'd23: rom_byte = 8'hEF;
      6'd24: rom_byte = 8'h21; // INVON
      6'd25: rom_byte = 8'h00;
      6'd26: rom_byte = 8'h13; // NORON
      6'd27: rom_byte = 8'h80;
      6'd28: rom_byte = 8'h03;
      6'd29: rom_byte = 8'h29; // DISPON
      6'd30: rom_byte = 8'h80;
      6'd31: rom_byte = 8'h03;
      6'd32: rom_byte = 8'h2C; // RAMWR, pixels follow
      6'd33: rom_byte = 8'h00;
      default: rom_byte = 8'h00; // Past the end reads as zero
    endcase
  end

endmodule

// File: design/lcd_pattern_gen.sv
// ############################
// RGB565 self-test gradient from x/y
// ############################

module lcd_pattern_gen
  import lcd_pixel_pkg::*;
(
  input  coord_x_t x,
  input  coord_y_t y,
  output pixel_t   color
);

  coord_x_t mix; // Checker-like blue channel

  assign mix = x ^ y;

  // Red ramps along x, green down y
  assign color = {
    x[7:3],   // Red
    y[7:2],   // Green
    mix[7:3]  // Blue
  };

endmodule

// File: design/lcd_video.sv
// ############################
// ST7789 video core: reset hold, init table
// walk, raster scan and SPI byte shifter
// ############################

`include "lcd_macros.svh"

module lcd_video
  import lcd_pixel_pkg::*, lcd_link_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  output coord_x_t   x,
  output coord_y_t   y,
  output logic       next_pixel, // Pulses as x/y advance
  input  pixel_t     color,
  output init_addr_t rom_addr,
  input  byte_t      rom_byte,
  output logic       oled_csn,
  output logic       oled_clk,
  output logic       oled_mosi,
  output logic       oled_dc,
  output logic       oled_resn
);

  localparam int slot_bits = $clog2(`LCD_SLOT_CYCLES);
  localparam logic [slot_bits-1:0] slot_last = slot_bits'(`LCD_SLOT_CYCLES - 1);
  localparam logic [31:0] reset_wait = 32'(`LCD_RESET_US * `LCD_CLK_MHZ - 1);
  localparam init_addr_t last_entry = init_addr_t'(`LCD_INIT_SIZE - 1);
  localparam init_addr_t table_size = init_addr_t'(`LCD_INIT_SIZE);
  localparam coord_x_t x_last = coord_x_t'(`LCD_X_SIZE - 1);
  localparam coord_y_t y_last = coord_y_t'(`LCD_Y_SIZE - 1);

  seq_state_t           state;
  seq_state_t           kind;       // Entry type read at the next load
  logic [slot_bits-1:0] slot_cnt;   // Bit 0 is the SPI clock
  logic                 active;     // A byte slot is on the wire
  logic                 slot_end;
  logic                 load;       // Start a new slot next cycle
  logic [31:0]          wait_cnt;   // Idle cycles left, minus one
  byte_t                shift_reg;
  byte_t                last_cmd;
  logic [4:0]           arg_left;
  logic                 delay_flag;
  logic                 pix_lo;     // Low colour byte is next
  logic                 dc;
  logic                 resn;

  // Where a record goes once its last byte is out
  function automatic seq_state_t record_next(input logic delay, input logic last);
    if (delay)
      return st_delay_code;
    else if (last)
      return st_pixels;
    else
      return st_cmd;
  endfunction

  assign slot_end = active && (slot_cnt == slot_last);
  assign load     = (!active || slot_end) && (wait_cnt == 32'd0);

  // After a wait the next entry is a command, or the pixels if the table is spent
  always_comb begin
    kind = state;
    if (state == st_reset_hold || state == st_delay)
      kind = (rom_addr == table_size) ? st_pixels : st_cmd;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_reset_hold;
      rom_addr   <= '0;
      slot_cnt   <= '0;
      active     <= 1'b0;
      wait_cnt   <= reset_wait;
      shift_reg  <= '0;
      arg_left   <= '0;
      delay_flag <= 1'b0;
      pix_lo     <= 1'b0;
      dc         <= 1'b0;
      resn       <= 1'b0;
      x          <= '0;
      y          <= '0;
      next_pixel <= 1'b0;
    end else begin
      next_pixel <= 1'b0;
      if (!active && wait_cnt != 32'd0)
        wait_cnt <= wait_cnt - 32'd1;    // Idle countdown
      if (active)
        slot_cnt <= slot_cnt + 1'b1;     // Wraps to 0 at slot end
      if (slot_end)
        active <= 1'b0;
      if (active && slot_cnt[0])
        shift_reg <= {shift_reg[6:0], 1'b0}; // Next bit on falling edge

      if (load) begin
        active   <= 1'b1;
        slot_cnt <= '0;
        resn     <= 1'b1;                // Panel out of reset for good
        if (kind != st_pixels)
          rom_addr <= rom_addr + 1'b1;
        case (kind)
          st_cmd: begin
            last_cmd  <= rom_byte;
            shift_reg <= 8'h00;          // NOP while the command is fetched
            dc        <= 1'b0;
            state     <= st_count;
          end
          st_count: begin
            arg_left   <= rom_byte[4:0];
            delay_flag <= rom_byte[7];
            shift_reg  <= last_cmd;
            dc         <= 1'b0;
            if (rom_byte[4:0] != 5'd0)
              state <= st_arg;
            else
              state <= record_next(rom_byte[7], rom_addr == last_entry);
          end
          st_arg: begin
            shift_reg <= rom_byte;
            dc        <= 1'b1;
            arg_left  <= arg_left - 5'd1;
            if (arg_left == 5'd1)
              state <= record_next(delay_flag, rom_addr == last_entry);
          end
          st_delay_code: begin
            shift_reg <= 8'h00;
            dc        <= 1'b0;
            // 2^n us, counted once the NOP slot is out
            wait_cnt  <= (32'(`LCD_CLK_MHZ) << rom_byte[4:0]) - 32'd1;
            state     <= st_delay;
          end
          st_pixels: begin
            dc     <= 1'b1;
            pix_lo <= ~pix_lo;
            if (!pix_lo) begin
              shift_reg <= color[15:8];  // High byte first
            end else begin
              shift_reg  <= color[7:0];
              next_pixel <= 1'b1;
              if (x == x_last) begin
                x <= '0;
                y <= (y == y_last) ? '0 : y + 1'b1;
              end else begin
                x <= x + 1'b1;
              end
            end
            state <= st_pixels;
          end
          default: state <= state;       // Wait states never load as themselves
        endcase
      end
    end
  end

  assign oled_clk  = slot_cnt[0];
  assign oled_mosi = shift_reg[7];       // MSB first
  assign oled_dc   = dc;
  assign oled_resn = resn;
  assign oled_csn  = resn;               // Board routes this to backlight enable

endmodule

// File: design/lcd_display_top.sv
// ############################
// Display top: init table, video core
// and test pattern onto the panel pins
// ############################

module lcd_display_top
  import lcd_pixel_pkg::*, lcd_link_pkg::*;
(
  input  logic clk,
  input  logic reset,
  output logic oled_csn,
  output logic oled_clk,
  output logic oled_mosi,
  output logic oled_dc,
  output logic oled_resn
);

  init_addr_t rom_addr;
  byte_t      rom_byte;
  coord_x_t   x;
  coord_y_t   y;
  pixel_t     color;

  lcd_init_rom lcd_init_rom_i (
    .rom_addr (rom_addr),
    .rom_byte (rom_byte)
  );

  lcd_video lcd_video_i (
    .clk        (clk),
    .reset      (reset),
    .x          (x),
    .y          (y),
    .next_pixel (),
    .color      (color),
    .rom_addr   (rom_addr),
    .rom_byte   (rom_byte),
    .oled_csn   (oled_csn),
    .oled_clk   (oled_clk),
    .oled_mosi  (oled_mosi),
    .oled_dc    (oled_dc),
    .oled_resn  (oled_resn)
  );

  lcd_pattern_gen lcd_pattern_gen_i (
    .x     (x),
    .y     (y),
    .color (color)
  );

endmodule

// File: verif/st7789_model.sv
// ############################
// ST7789 panel model: rebuilds SPI bytes,
// drops NOPs, reports each byte and gap
// ############################

module st7789_model
  import lcd_link_pkg::*;
(
  input  logic        clk,
  input  logic        oled_csn,
  input  logic        oled_clk,
  input  logic        oled_mosi,
  input  logic        oled_dc,
  input  logic        oled_resn,
  output logic        byte_valid, // One cycle per kept byte
  output byte_t       byte_data,
  output logic        byte_dc,
  output int unsigned byte_gap    // Cycles since previous kept byte
);

  logic        sck_q;      // SPI clock one cycle ago
  logic [2:0]  bit_cnt;
  byte_t       shift;
  byte_t       next_byte;
  int unsigned cycle;      // Free running cycle count
  int unsigned last_cycle;

  initial begin
    sck_q      = 1'b0;
    bit_cnt    = '0;
    shift      = '0;
    cycle      = 0;
    last_cycle = 0;
    byte_valid = 1'b0;
    byte_data  = '0;
    byte_dc    = 1'b0;
    byte_gap   = 0;
  end

  always @(posedge clk) begin
    cycle      <= cycle + 1;
    byte_valid <= 1'b0;
    sck_q      <= oled_clk;
    if (oled_resn !== 1'b1 || oled_csn !== 1'b1) begin
      bit_cnt <= '0;                          // Panel in reset, no framing
    end else if (oled_clk && !sck_q) begin    // Rising SPI clock seen
      next_byte = {shift[6:0], oled_mosi};    // MSB first
      shift   <= next_byte;
      bit_cnt <= bit_cnt + 3'd1;
      // NOP is a zero byte with dc low
      if (bit_cnt == 3'd7 && (oled_dc || next_byte != 8'h00)) begin
        byte_valid <= 1'b1;
        byte_data  <= next_byte;
        byte_dc    <= oled_dc;                // dc held for the whole slot
        byte_gap   <= cycle - last_cycle;
        last_cycle <= cycle;
      end
    end
  end

endmodule

// File: verif/lcd_display_tb.sv
// ############################
// Testbench for the ST7789 display path
// init bytes, delay gaps and pixel stream
// ############################

`include "lcd_macros.svh"

module lcd_display_tb
  import lcd_pixel_pkg::*, lcd_link_pkg::*;
();

  localparam int clk_period   = 20;
  localparam int max_entries  = 20;                      // Init bytes in the file
  localparam int stim_words   = 2 + 3 * max_entries;
  localparam int hold_cycles  = `LCD_RESET_US * `LCD_CLK_MHZ;
  localparam int frame_pixels = `LCD_X_SIZE * `LCD_Y_SIZE;

  logic        clk = 1'b0;
  logic        reset;
  logic        oled_csn, oled_clk, oled_mosi, oled_dc, oled_resn;
  logic        byte_valid;
  byte_t       byte_data;
  logic        byte_dc;
  int unsigned byte_gap;
  logic [15:0] stim [0:stim_words-1];                    // Counts, then dc/byte/gap
  logic        cfg_ready  = 1'b0;
  logic        reset_seen = 1'b0;
  logic        resn_up    = 1'b0;
  int unsigned hold_cnt   = 0;                           // Cycles with resn low
  int unsigned n_init, pix_count, rand_idx;

  always #(clk_period / 2) clk = ~clk;

  lcd_display_top lcd_display_top_i (
    .clk       (clk),
    .reset     (reset),
    .oled_csn  (oled_csn),
    .oled_clk  (oled_clk),
    .oled_mosi (oled_mosi),
    .oled_dc   (oled_dc),
    .oled_resn (oled_resn)
  );

  st7789_model st7789_model_i (
    .clk        (clk),
    .oled_csn   (oled_csn),
    .oled_clk   (oled_clk),
    .oled_mosi  (oled_mosi),
    .oled_dc    (oled_dc),
    .oled_resn  (oled_resn),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .byte_dc    (byte_dc),
    .byte_gap   (byte_gap)
  );

  task automatic stop_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic value_error(input string what, input longint unsigned exp,
                             input longint unsigned got);
    $display("** Error at time %0t: %s, expected 0x%0h, got 0x%0h", $time, what, exp, got);
    stop_run();
  endtask

  // Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // Test image: red from x, green from y, blue from x xor y
  function automatic pixel_t color_at(input int unsigned px, input int unsigned py);
    logic [7:0] xb, yb, mix;
    xb  = px[7:0];
    yb  = py[7:0];
    mix = xb ^ yb;
    return {xb[7:3], yb[7:2], mix[7:3]};
  endfunction

  // Waits for the next kept byte and checks the gap before it
  task automatic take_byte(input int unsigned min_gap, output logic dc, output byte_t data);
    @(posedge clk);
    while (byte_valid !== 1'b1)
      @(posedge clk);
    dc   = byte_dc;
    data = byte_data;
    assert (byte_gap >= min_gap) else value_error("cycles before byte", min_gap, byte_gap);
  endtask

  // Panel reset and chip select around the hold time
  always @(posedge clk) begin
    if (reset) begin
      if (reset_seen)
        assert (!oled_resn && !oled_csn && !oled_clk)
          else value_error("resn/csn/clk in reset", 3'b000, {oled_resn, oled_csn, oled_clk});
      reset_seen <= 1'b1;
    end else if (reset_seen && !resn_up) begin
      assert (oled_csn == oled_resn) else value_error("csn against resn", oled_resn, oled_csn);
      if (oled_resn) begin
        assert (hold_cnt >= hold_cycles) else value_error("reset hold", hold_cycles, hold_cnt);
        resn_up <= 1'b1;
      end else begin
        hold_cnt <= hold_cnt + 1;
      end
    end else if (resn_up) begin
      assert (oled_resn && oled_csn) else value_error("resn/csn high", 2'b11, {oled_resn, oled_csn});
    end
  end

  initial begin
    int unsigned min_gap, base;
    logic        got_dc, dc_lo;
    byte_t       got, lo;
    logic [31:0] seed;
    logic [15:0] rnd;
    pixel_t      want;
    reset = 1'b1;
    $readmemh("verif/lcd_input.txt", stim);
    assert (!$isunknown(stim[0]) && !$isunknown(stim[1]) && stim[0] != 0
            && stim[0] <= max_entries && stim[1] != 0)
      else begin
        $display("Stimulus file verif/lcd_input.txt is missing or malformed");
        stop_run();
      end
    n_init    = stim[0];
    pix_count = stim[1];
    seed = 32'h5ec46360;
    rnd  = '0;
    repeat (16) begin
      seed = lfsr_next(seed);
      rnd  = {rnd[14:0], seed[0]};                      // One step per bit
    end
    rand_idx = rnd % pix_count;
    $display("Random pixel index %0d, x %0d, y %0d", rand_idx,
             rand_idx % `LCD_X_SIZE, (rand_idx / `LCD_X_SIZE) % `LCD_Y_SIZE);
    cfg_ready = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    min_gap = 0;
    for (int unsigned i = 0; i < n_init; i++) begin
      base = 2 + 3 * i;
      take_byte(min_gap, got_dc, got);
      assert (got_dc == stim[base][0]) else value_error("init dc", stim[base][0], got_dc);
      assert (got == stim[base+1][7:0]) else value_error("init byte", stim[base+1], got);
      min_gap = stim[base+2];                           // Applies to the next byte
    end
    for (int unsigned k = 0; k < pix_count; k++) begin
      take_byte(min_gap, got_dc, got);                  // High byte
      min_gap = `LCD_SLOT_CYCLES;
      take_byte(min_gap, dc_lo, lo);
      assert (got_dc && dc_lo) else value_error("pixel dc", 2'b11, {got_dc, dc_lo});
      want = color_at(k % `LCD_X_SIZE, (k / `LCD_X_SIZE) % `LCD_Y_SIZE);
      if (k == rand_idx) begin
        $display("Pixel %0d read back as 0x%04h", k, {got, lo});
        assert ({got, lo} == want) else value_error("random pixel", want, {got, lo});
      end
      if (k == frame_pixels) begin
        assert ({got, lo} == color_at(0, 0))
          else value_error("frame wrap pixel", color_at(0, 0), {got, lo});
      end
      assert ({got, lo} == want) else value_error($sformatf("pixel %0d", k), want, {got, lo});
    end
    $display("Test OK");
    $finish;
  end

  // Twice the nominal run length in cycles
  initial begin
    longint unsigned budget;
    wait (cfg_ready);
    budget = 2 * (hold_cycles + `LCD_INIT_SIZE * `LCD_SLOT_CYCLES
                  + 4 * (`LCD_CLK_MHZ << 3) + pix_count * 2 * `LCD_SLOT_CYCLES);
    #(budget * clk_period);
    $display("Timeout: the pixel stream stalled, no end after %0d cycles", budget);
    stop_run();
  end

endmodule

// File: verif/lcd_input.txt
// Header words: init entry count, pixel count to check (hex)
// Init entries: dc, byte, minimum cycles before the next kept byte (hex)
14
e1f0
0 01 c8 // SWRESET
0 11 c8 // SLPOUT
0 3a 10 // COLMOD
1 55 10
0 36 10 // MADCTL
1 00 10
0 2a 10 // CASET
1 00 10
1 00 10
1 00 10
1 ef 10
0 2b 10 // RASET
1 00 10
1 00 10
1 00 10
1 ef 10
0 21 10 // INVON
0 13 c8 // NORON
0 29 c8 // DISPON
0 2c 10 // RAMWR

// File: list.f
+incdir+include
design/lcd_pixel_pkg.sv
design/lcd_link_pkg.sv
design/lcd_init_rom.sv
design/lcd_pattern_gen.sv
design/lcd_video.sv
design/lcd_display_top.sv
verif/st7789_model.sv
verif/lcd_display_tb.sv

// File: Bender.yml
package:
  name: lcd_display

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/lcd_pixel_pkg.sv
      - design/lcd_link_pkg.sv
      - design/lcd_init_rom.sv
      - design/lcd_pattern_gen.sv
      - design/lcd_video.sv
      - design/lcd_display_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/st7789_model.sv
      - verif/lcd_display_tb.sv
